/* verilog/tetris_defs.svh */
// Tetris sprint core constants
// playfield size, spawn cell, auto-shift timing and timer prescale
`ifndef TETRIS_DEFS_SVH
`define TETRIS_DEFS_SVH

// playfield
`define PLAYFIELD_ROWS 20
`define PLAYFIELD_COLS 10
`define POS_WIDTH      5

// spawn cell of the piece origin
`define SPAWN_ROW      0
`define SPAWN_COL      4

// delayed auto shift, in clock cycles
`define DAS_DELAY      16
`define DAS_REPEAT     4

// 50 MHz clock
`define CYCLES_PER_MS  50000

`endif

/* verilog/tetris_pkg.sv */
// Tetris sprint core types
// button, action, position, screen and timer words
`default_nettype none

`include "tetris_defs.svh"

package tetris_pkg;

    // raw button levels, active high
    typedef struct packed {
        logic start;
        logic move_l;
        logic move_r;
        logic soft_drop;
    } buttons_t;

    // action pulses or per-action valid flags
    typedef struct packed {
        logic move_l;
        logic move_r;
        logic soft_drop;
    } actions_t;

    typedef struct packed {
        logic [`POS_WIDTH-1:0] row;
        logic [`POS_WIDTH-1:0] col;
    } piece_pos_t;

    typedef enum logic [1:0] {
        SCREEN_IDLE     = 2'd0,
        SCREEN_PLAYING  = 2'd1,
        SCREEN_FINISHED = 2'd2
    } game_screen_t;

    typedef struct packed {
        logic [4:0] hours;
        logic [5:0] minutes;
        logic [5:0] seconds;
        logic [3:0] deciseconds;
        logic [3:0] centiseconds;
        logic [3:0] milliseconds;
    } game_time_t;

endpackage

`default_nettype wire

/* verilog/input_das.sv */
// Delayed auto shift for one button
// synchronizes the level, emits a first pulse and then timed repeats
`default_nettype none

`include "tetris_defs.svh"

module input_das (
    input  logic clk,
    input  logic rst_l,
    input  logic button,
    input  logic valid,
    output logic action
);

    localparam int CNT_W = $clog2(`DAS_DELAY + 1);

    logic [1:0]       sync;
    logic [CNT_W-1:0] held_cnt;
    logic             first_rep_done;
    logic             slot;

    // two flop synchronizer
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            sync <= 2'b00;
        end else begin
            sync <= {sync[0], button};
        end
    end

    // held_cnt counts cycles since the last pulse slot
    // zero only in the first held cycle
    always_comb begin
        slot = 1'b0;
        if (sync[1]) begin
            if (held_cnt == '0) begin
                slot = 1'b1;
            end else if (!first_rep_done) begin
                slot = (held_cnt == CNT_W'(`DAS_DELAY));
            end else begin
                slot = (held_cnt == CNT_W'(`DAS_REPEAT));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            held_cnt       <= '0;
            first_rep_done <= 1'b0;
        end else if (!sync[1]) begin
            held_cnt       <= '0;
            first_rep_done <= 1'b0;
        end else if (slot) begin
            held_cnt <= CNT_W'(1);
            // first slot is the press itself, not a repeat
            if (held_cnt != '0) begin
                first_rep_done <= 1'b1;
            end
        end else begin
            held_cnt <= held_cnt + CNT_W'(1);
        end
    end

    // blocked slots are dropped, the schedule keeps running
    assign action = slot && valid;

    // pulses are valid and never back to back
    a_action_valid : assert property (@(posedge clk) disable iff (!rst_l)
        action |-> valid ##1 !action);

endmodule

`default_nettype wire

/* verilog/piece_position.sv */
// Falling piece origin
// applies move and drop pulses, checks the walls and the floor
`default_nettype none

`include "tetris_defs.svh"

module piece_position (
    input  logic                  clk,
    input  logic                  rst_l,
    input  tetris_pkg::actions_t  actions,
    input  logic                  game_start,
    output tetris_pkg::piece_pos_t piece,
    output tetris_pkg::actions_t  action_valid,
    output logic                  at_floor
);

    localparam logic [`POS_WIDTH-1:0] LAST_ROW = `POS_WIDTH'(`PLAYFIELD_ROWS - 1);
    localparam logic [`POS_WIDTH-1:0] LAST_COL = `POS_WIDTH'(`PLAYFIELD_COLS - 1);

    tetris_pkg::piece_pos_t piece_next;

    // wall and floor checks
    always_comb begin
        action_valid.move_l    = (piece.col != '0);
        action_valid.move_r    = (piece.col != LAST_COL);
        action_valid.soft_drop = (piece.row != LAST_ROW);
    end

    assign at_floor = (piece.row == LAST_ROW);

    // pulses arrive already qualified, no bounds recheck here
    always_comb begin
        piece_next = piece;
        if (game_start) begin
            piece_next.row = `POS_WIDTH'(`SPAWN_ROW);
            piece_next.col = `POS_WIDTH'(`SPAWN_COL);
        end else begin
            // right wins over left
            if (actions.move_r) begin
                piece_next.col = piece.col + `POS_WIDTH'(1);
            end else if (actions.move_l) begin
                piece_next.col = piece.col - `POS_WIDTH'(1);
            end
            if (actions.soft_drop) begin
                piece_next.row = piece.row + `POS_WIDTH'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            piece.row <= `POS_WIDTH'(`SPAWN_ROW);
            piece.col <= `POS_WIDTH'(`SPAWN_COL);
        end else begin
            piece <= piece_next;
        end
    end

    a_col_range : assert property (@(posedge clk) disable iff (!rst_l)
        piece.col < `POS_WIDTH'(`PLAYFIELD_COLS));
    a_row_range : assert property (@(posedge clk) disable iff (!rst_l)
        piece.row < `POS_WIDTH'(`PLAYFIELD_ROWS));

endmodule

`default_nettype wire

/* verilog/game_screens_fsm.sv */
// Game screen FSM
// idle, playing and finished screens of a sprint
`default_nettype none

module game_screens_fsm (
    input  logic                     clk,
    input  logic                     rst_l,
    input  logic                     start,
    input  logic                     at_floor,
    output tetris_pkg::game_screen_t screen,
    output logic                     game_start,
    output logic                     playing
);

    logic [1:0]               start_sync;
    logic                     start_prev;
    tetris_pkg::game_screen_t screen_next;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            start_sync <= 2'b00;
            start_prev <= 1'b0;
            screen     <= tetris_pkg::SCREEN_IDLE;
        end else begin
            start_sync <= {start_sync[0], start};
            start_prev <= start_sync[1];
            screen     <= screen_next;
        end
    end

    // start edge only counts outside a running sprint
    assign game_start = start_sync[1] && !start_prev &&
                        (screen != tetris_pkg::SCREEN_PLAYING);
    assign playing    = (screen == tetris_pkg::SCREEN_PLAYING);

    always_comb begin
        screen_next = screen;
        case (screen)
            tetris_pkg::SCREEN_IDLE,
            tetris_pkg::SCREEN_FINISHED: if (game_start) screen_next = tetris_pkg::SCREEN_PLAYING;
            tetris_pkg::SCREEN_PLAYING:  if (at_floor) screen_next = tetris_pkg::SCREEN_FINISHED;
            default:                     screen_next = tetris_pkg::SCREEN_IDLE;
        endcase
    end

    // a start lands in playing and cannot retrigger there
    a_start_once : assert property (@(posedge clk) disable iff (!rst_l)
        game_start |=> (screen == tetris_pkg::SCREEN_PLAYING) && !game_start);

endmodule

`default_nettype wire

/* verilog/sprint_timer.sv */
// Sprint timer
// prescaled millisecond tick feeding cascaded counters up to hours
`default_nettype none

`include "tetris_defs.svh"

module sprint_timer #(
    parameter int cycles_per_ms = `CYCLES_PER_MS
) (
    input  logic                   clk,
    input  logic                   rst_l,
    input  logic                   game_start,
    input  logic                   playing,
    output tetris_pkg::game_time_t game_time
);

    localparam int PRE_W = $clog2(cycles_per_ms);

    logic [PRE_W-1:0] prescale;
    logic             ms_en;
    logic             cs_en;
    logic             ds_en;
    logic             sec_en;
    logic             min_en;
    logic             hr_en;

    // each enable is the carry out of the digit below
    always_comb begin
        ms_en  = playing && (prescale == PRE_W'(cycles_per_ms - 1));
        cs_en  = ms_en  && (game_time.milliseconds == 4'd9);
        ds_en  = cs_en  && (game_time.centiseconds == 4'd9);
        sec_en = ds_en  && (game_time.deciseconds == 4'd9);
        min_en = sec_en && (game_time.seconds == 6'd59);
        hr_en  = min_en && (game_time.minutes == 6'd59);
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            prescale <= '0;
        end else if (game_start || ms_en) begin
            prescale <= '0;
        end else if (playing) begin
            prescale <= prescale + PRE_W'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            game_time <= '0;
        end else if (game_start) begin
            game_time <= '0;
        end else begin
            if (ms_en) begin
                game_time.milliseconds <= cs_en ? 4'd0 : game_time.milliseconds + 4'd1;
            end
            if (cs_en) begin
                game_time.centiseconds <= ds_en ? 4'd0 : game_time.centiseconds + 4'd1;
            end
            if (ds_en) begin
                game_time.deciseconds <= sec_en ? 4'd0 : game_time.deciseconds + 4'd1;
            end
            if (sec_en) begin
                game_time.seconds <= min_en ? 6'd0 : game_time.seconds + 6'd1;
            end
            if (min_en) begin
                game_time.minutes <= hr_en ? 6'd0 : game_time.minutes + 6'd1;
            end
            // hours just wrap
            if (hr_en) begin
                game_time.hours <= game_time.hours + 5'd1;
            end
        end
    end

    a_digit_range : assert property (@(posedge clk) disable iff (!rst_l)
        (game_time.milliseconds <= 4'd9) && (game_time.centiseconds <= 4'd9) &&
        (game_time.deciseconds <= 4'd9) && (game_time.seconds <= 6'd59) &&
        (game_time.minutes <= 6'd59));

endmodule

`default_nettype wire

/* verilog/tetris_top.sv */
// Tetris sprint core top level
// button conditioning, piece origin, screen FSM and sprint timer
`default_nettype none

`include "tetris_defs.svh"

module tetris_top #(
    parameter int cycles_per_ms = `CYCLES_PER_MS
) (
    input  logic                     clk,
    input  logic                     rst_l,
    input  tetris_pkg::buttons_t     buttons,
    output tetris_pkg::piece_pos_t   piece,
    output tetris_pkg::game_screen_t screen,
    output tetris_pkg::game_time_t   game_time
);

    tetris_pkg::actions_t actions;
    tetris_pkg::actions_t action_valid;
    logic                 game_start;
    logic                 playing;
    logic                 at_floor;

    // one DAS per movement button
    input_das i_das_move_l (
        .clk    (clk),
        .rst_l  (rst_l),
        .button (buttons.move_l),
        .valid  (action_valid.move_l),
        .action (actions.move_l)
    );
    input_das i_das_move_r (
        .clk    (clk),
        .rst_l  (rst_l),
        .button (buttons.move_r),
        .valid  (action_valid.move_r),
        .action (actions.move_r)
    );
    input_das i_das_soft_drop (
        .clk    (clk),
        .rst_l  (rst_l),
        .button (buttons.soft_drop),
        .valid  (action_valid.soft_drop),
        .action (actions.soft_drop)
    );

    piece_position i_piece_position (
        .clk          (clk),
        .rst_l        (rst_l),
        .actions      (actions),
        .game_start   (game_start),
        .piece        (piece),
        .action_valid (action_valid),
        .at_floor     (at_floor)
    );

    game_screens_fsm i_game_screens_fsm (
        .clk        (clk),
        .rst_l      (rst_l),
        .start      (buttons.start),
        .at_floor   (at_floor),
        .screen     (screen),
        .game_start (game_start),
        .playing    (playing)
    );

    sprint_timer #(
        .cycles_per_ms (cycles_per_ms)
    ) i_sprint_timer (
        .clk        (clk),
        .rst_l      (rst_l),
        .game_start (game_start),
        .playing    (playing),
        .game_time  (game_time)
    );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
// Testbench clock and reset
// 20 ns clock, active low reset held for 16 cycles
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_l
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_l = 1'b0;
        repeat (16) @(posedge clk);
        rst_l <= 1'b1;
    end

endmodule

`default_nettype wire

/* dv/tetris_tb.sv */
// Testbench for the Tetris sprint core
// random presses checked against a model of origin, screen and timer
`default_nettype none

`include "tetris_defs.svh"

module tetris_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam tetris_pkg::buttons_t BTN_S = 4'b1000;
    localparam tetris_pkg::buttons_t BTN_L = 4'b0100;
    localparam tetris_pkg::buttons_t BTN_R = 4'b0010;
    localparam tetris_pkg::buttons_t BTN_D = 4'b0001;
    localparam tetris_pkg::buttons_t MOVES [3] = '{BTN_L, BTN_R, BTN_D};
    localparam tetris_pkg::piece_pos_t SPAWN = '{row: `POS_WIDTH'(`SPAWN_ROW),
                                                 col: `POS_WIDTH'(`SPAWN_COL)};

    logic                     clk;
    logic                     rst_l;
    tetris_pkg::buttons_t     buttons;
    tetris_pkg::piece_pos_t   piece;
    tetris_pkg::game_screen_t screen;
    tetris_pkg::game_time_t   game_time;

    // model state
    int                       exp_row;
    int                       exp_col;
    int                       play_cycles;
    int                       d_row;
    int                       d_col;
    int                       r;
    int                       n;
    tetris_pkg::piece_pos_t   last_piece = SPAWN;
    tetris_pkg::game_screen_t last_screen = tetris_pkg::SCREEN_IDLE;

    tb_clock i_tb_clock (
        .clk   (clk),
        .rst_l (rst_l)
    );

    tetris_top #(
        .cycles_per_ms (8)
    ) i_tetris_top (
        .clk       (clk),
        .rst_l     (rst_l),
        .buttons   (buttons),
        .piece     (piece),
        .screen    (screen),
        .game_time (game_time)
    );

    function automatic int total_ms(tetris_pkg::game_time_t t);
        return t.hours * 3600000 + t.minutes * 60000 + t.seconds * 1000 +
               t.deciseconds * 100 + t.centiseconds * 10 + t.milliseconds;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(string name, int expected, int actual, int tol);
        assert (actual >= expected - tol && actual <= expected + tol) else begin
            fail_run($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_piece(string name);
        check_value({name, " row"}, exp_row, piece.row, 0);
        check_value({name, " col"}, exp_col, piece.col, 0);
    endtask

    task automatic wait_screen(tetris_pkg::game_screen_t want, int limit);
        int k;
        k = 0;
        do begin
            @(negedge clk);
            k++;
            if (k > limit) fail_run($sformatf("timeout waiting for screen %s", want.name()));
        end while (screen != want);
    endtask

    // one applied pulse, blocked at the walls and the floor
    task automatic apply_step(tetris_pkg::buttons_t mask);
        if (mask.move_r) begin
            if (exp_col < `PLAYFIELD_COLS - 1) exp_col++;
        end else if (mask.move_l) begin
            if (exp_col > 0) exp_col--;
        end
        if (mask.soft_drop && exp_row < `PLAYFIELD_ROWS - 1) exp_row++;
    endtask

    task automatic press(tetris_pkg::buttons_t mask, int len, int gap);
        @(posedge clk);
        buttons <= mask;
        repeat (len) @(posedge clk);
        buttons <= '0;
        repeat (gap) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic short_step(tetris_pkg::buttons_t mask);
        press(mask, 3 + $urandom_range(12), 4 + $urandom_range(8));
        apply_step(mask);
        check_piece("single step");
    endtask

    // slots at held cycle 0, DAS_DELAY, then every DAS_REPEAT
    task automatic long_hold(tetris_pkg::buttons_t mask);
        int len;
        int steps;
        len = 40 + $urandom_range(80);
        steps = 2 + (len - 1 - `DAS_DELAY) / `DAS_REPEAT;
        press(mask, len, 8);
        repeat (steps) apply_step(mask);
        check_piece("auto-repeat");
    endtask

    task automatic hold_to_wall(tetris_pkg::buttons_t mask, int wall);
        int k;
        k = 0;
        while (exp_col != wall) begin
            long_hold(mask);
            k++;
            if (k > 4) fail_run("auto-repeat never reached the wall");
        end
        check_value("auto-repeat wall", wall, piece.col, 0);
        short_step(mask);
    endtask

    task automatic start_sprint();
        @(posedge clk);
        buttons <= BTN_S;
        wait_screen(tetris_pkg::SCREEN_PLAYING, 20);
        exp_row = `SPAWN_ROW;
        exp_col = `SPAWN_COL;
        check_piece("start spawn");
        check_value("start time", 0, total_ms(game_time), 0);
        @(posedge clk);
        buttons <= '0;
        repeat (4) @(negedge clk);
    endtask

    task automatic timer_rate(int cycles);
        int t0;
        t0 = total_ms(game_time);
        repeat (cycles) @(negedge clk);
        check_value("timer rate", t0 + cycles / 8, total_ms(game_time), 1);
    endtask

    task automatic freeze_check(int cycles);
        tetris_pkg::piece_pos_t p0;
        int t0;
        @(negedge clk);
        p0 = piece;
        t0 = total_ms(game_time);
        repeat (cycles) begin
            @(negedge clk);
            check_value("frozen piece", p0, piece, 0);
            check_value("frozen time", t0, total_ms(game_time), 0);
            check_value("finished screen", tetris_pkg::SCREEN_FINISHED, screen, 0);
        end
    endtask

    task automatic finish_sprint();
        @(posedge clk);
        buttons <= BTN_D;
        wait_screen(tetris_pkg::SCREEN_FINISHED, 400);
        exp_row = `PLAYFIELD_ROWS - 1;
        check_piece("sprint end");
        // drop still held while frozen at the floor
        freeze_check(200);
        @(posedge clk);
        buttons <= '0;
        repeat (4) @(negedge clk);
        // floor blocks a further drop
        short_step(BTN_D);
    endtask

    // per cycle rules, sampled away from the active edge
    always @(negedge clk) begin
        if (rst_l) begin
            assert (piece.row < `PLAYFIELD_ROWS && piece.col < `PLAYFIELD_COLS)
                else fail_run("piece origin left the playfield");
            // only a start may jump the origin back to spawn
            if (screen != tetris_pkg::SCREEN_PLAYING ||
                last_screen == tetris_pkg::SCREEN_PLAYING) begin
                d_row = int'(piece.row) - int'(last_piece.row);
                d_col = int'(piece.col) - int'(last_piece.col);
                assert (d_row >= 0 && d_row <= 1 && d_col >= -1 && d_col <= 1)
                    else fail_run("piece origin moved by more than one cell");
            end
            if (screen == tetris_pkg::SCREEN_PLAYING) begin
                if (last_screen != tetris_pkg::SCREEN_PLAYING) play_cycles = 0;
                play_cycles++;
                assert (game_time.milliseconds <= 9 && game_time.centiseconds <= 9 &&
                        game_time.deciseconds <= 9 && game_time.seconds <= 59 &&
                        game_time.minutes <= 59)
                    else fail_run("timer digit out of range");
                check_value("elapsed time", play_cycles / 8, total_ms(game_time), 1);
            end
            last_piece = piece;
            last_screen = screen;
        end
    end

    initial begin
        buttons = '0;
        play_cycles = 0;
        exp_row = `SPAWN_ROW;
        exp_col = `SPAWN_COL;
        void'($urandom(12));

        n = 0;
        while (!rst_l) begin
            @(negedge clk);
            n++;
            if (n > 100) fail_run("reset was never released");
        end
        @(negedge clk);
        check_value("reset screen", tetris_pkg::SCREEN_IDLE, screen, 0);
        check_piece("reset piece");
        check_value("reset time", 0, total_ms(game_time), 0);

        start_sprint();
        repeat (40) begin
            r = $urandom_range(2);
            // keep clear of the floor until the sprint end
            if (r == 2 && exp_row >= 10) r = $urandom_range(1);
            short_step(MOVES[r]);
        end

        hold_to_wall(BTN_R, `PLAYFIELD_COLS - 1);
        hold_to_wall(BTN_L, 0);
        hold_to_wall(BTN_R, `PLAYFIELD_COLS - 1);
        finish_sprint();

        start_sprint();
        timer_rate(9000);
        repeat (5) timer_rate(50 + $urandom_range(1500));
        finish_sprint();
        start_sprint();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
verilog/tetris_pkg.sv
verilog/input_das.sv
verilog/piece_position.sv
verilog/game_screens_fsm.sv
verilog/sprint_timer.sv
verilog/tetris_top.sv
dv/tb_clock.sv
dv/tetris_tb.sv

/* Bender.yml */
package:
  name: tetris_sprint

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tetris_pkg.sv
      - verilog/input_das.sv
      - verilog/piece_position.sv
      - verilog/game_screens_fsm.sv
      - verilog/sprint_timer.sv
      - verilog/tetris_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_clock.sv
      - dv/tetris_tb.sv
